// File: src/ptw_config.svh
/*
 * sizing macros for the Sv39 page-table walker
 * address widths, page number widths, level count, page offset
 */

`ifndef PTW_CONFIG_SVH
`define PTW_CONFIG_SVH

// Sv39 virtual address
`define PTW_VLEN 39
// physical address and page number
`define PTW_PLEN 56
`define PTW_PPNW 44
// address space id from satp
`define PTW_ASIDW 16
// three table levels, 4k pages
`define PTW_LEVELS 3
`define PTW_PGOFF 12

`endif

// File: src/ptw_pkg.sv
/*
 * types shared by the walker stages
 * PTE layout and union, level and verdict enums,
 * walk request, memory port and TLB update structs
 */

`include "ptw_config.svh"

package ptw_pkg;

    // Sv39 PTE, msb first
    typedef struct packed {
        logic [9:0]            reserved;
        logic [`PTW_PPNW-1:0]  ppn;
        logic [1:0]            rsw;
        logic                  d;
        logic                  a;
        logic                  g;
        logic                  u;
        logic                  x;
        logic                  w;
        logic                  r;
        logic                  v;
    } pte_fields_t;

    // raw word goes to the TLB, field view is checked
    typedef union packed {
        logic [63:0]  raw;
        pte_fields_t  fields;
    } pte_word_u;

    typedef enum logic [$clog2(`PTW_LEVELS)-1:0] {
        lvl_1g,
        lvl_2m,
        lvl_4k
    } ptw_lvl_e;

    typedef enum logic [1:0] {
        v_leaf,
        v_next,
        v_fault
    } pte_verdict_e;

    typedef struct packed {
        logic                   is_instr;
        logic                   is_store;
        logic [`PTW_VLEN-1:0]   vaddr;
        logic [`PTW_ASIDW-1:0]  asid;
        logic [`PTW_PLEN-1:0]   root_ptr;
    } walk_req_t;

    typedef struct packed {
        logic                  req;
        logic [`PTW_PLEN-1:0]  addr;
    } mem_req_t;

    typedef struct packed {
        logic         gnt;
        logic         rvalid;
        logic [63:0]  rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                             valid;
        logic                             is_instr;
        logic                             is_2m;
        logic                             is_1g;
        logic [`PTW_VLEN-`PTW_PGOFF-1:0]  vpn;
        logic [`PTW_ASIDW-1:0]            asid;
        logic [63:0]                      content;
    } tlb_update_t;

endpackage

// File: src/ptw_miss_select.sv
/*
 * miss selector
 * picks an ITLB or DTLB miss while the walker is free
 * and registers the root-table walk request
 */

`include "ptw_config.svh"

module ptw_miss_select import ptw_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   busy_i,
    input  logic                   en_instr_i,
    input  logic                   en_data_i,
    input  logic                   itlb_access_i,
    input  logic                   itlb_hit_i,
    input  logic                   dtlb_access_i,
    input  logic                   dtlb_hit_i,
    input  logic [`PTW_VLEN-1:0]   itlb_vaddr_i,
    input  logic [`PTW_VLEN-1:0]   dtlb_vaddr_i,
    input  logic                   lsu_is_store_i,
    input  logic [`PTW_ASIDW-1:0]  asid_i,
    input  logic [`PTW_PPNW-1:0]   satp_ppn_i,
    output logic                   start_o,
    output walk_req_t              walk_o,
    output logic                   itlb_miss_o,
    output logic                   dtlb_miss_o
);

    logic [`PTW_VLEN-1:0] sel_vaddr;

    // instruction side only goes when no data access is pending
    assign itlb_miss_o = en_instr_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i & ~busy_i;
    assign dtlb_miss_o = en_data_i & dtlb_access_i & ~dtlb_hit_i & ~busy_i;

    assign sel_vaddr = itlb_miss_o ? itlb_vaddr_i : dtlb_vaddr_i;

    // start strobe follows the miss by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_o <= 1'b0;
        end else begin
            start_o <= itlb_miss_o | dtlb_miss_o;
        end
    end

    // request held stable until the next accepted miss
    always_ff @(posedge clk_i) begin
        if (itlb_miss_o || dtlb_miss_o) begin
            walk_o.is_instr <= itlb_miss_o;
            walk_o.is_store <= dtlb_miss_o & lsu_is_store_i;
            walk_o.vaddr    <= sel_vaddr;
            walk_o.asid     <= asid_i;
            // root table entry: satp ppn, vpn[2], 8 byte PTE
            walk_o.root_ptr <= {satp_ppn_i, sel_vaddr[`PTW_VLEN-1:`PTW_VLEN-9], 3'b000};
        end
    end

endmodule

// File: src/ptw_pte_check.sv
/*
 * PTE checker, combinational
 * classifies a PTE as leaf, pointer or fault for the current
 * level and access kind, forms the next-level table pointer
 */

`include "ptw_config.svh"

module ptw_pte_check import ptw_pkg::*; (
    input  pte_word_u             pte_i,
    input  ptw_lvl_e              lvl_i,
    input  logic                  is_instr_i,
    input  logic                  is_store_i,
    input  logic                  mxr_i,
    input  logic [`PTW_VLEN-1:0]  vaddr_i,
    output pte_verdict_e          verdict_o,
    output logic [`PTW_PLEN-1:0]  next_ptr_o
);

    // one vpn slice per level
    localparam int vpn_w = 9;

    pte_fields_t       pte;
    logic              bad_encoding;
    logic              is_pointer;
    logic              perm_ok;
    logic              misaligned;
    logic [vpn_w-1:0]  next_vpn;

    assign pte = pte_i.fields;

    // ------------------------------
    // encoding
    // ------------------------------
    // invalid, or writable without readable
    assign bad_encoding = !pte.v || (pte.w && !pte.r);
    // neither r nor x means next table
    assign is_pointer   = !pte.r && !pte.x;

    // ------------------------------
    // leaf permissions
    // ------------------------------
    always_comb begin
        if (is_instr_i) begin
            // fetch needs execute, accessed bit is managed by software
            perm_ok = pte.x && pte.a;
        end else begin
            // load: readable, or executable with mxr
            perm_ok = pte.a && (pte.r || (pte.x && mxr_i));
            // store also needs write and dirty
            if (is_store_i && (!pte.w || !pte.d)) begin
                perm_ok = 1'b0;
            end
        end
    end

    // superpage leaves must have clear low ppn bits
    always_comb begin
        case (lvl_i)
            lvl_1g:  misaligned = pte.ppn[2*vpn_w-1:0] != '0;
            lvl_2m:  misaligned = pte.ppn[vpn_w-1:0] != '0;
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (bad_encoding) begin
            verdict_o = v_fault;
        end else if (is_pointer) begin
            // no table below the 4k level
            verdict_o = (lvl_i == lvl_4k) ? v_fault : v_next;
        end else if (perm_ok && !misaligned) begin
            verdict_o = v_leaf;
        end else begin
            verdict_o = v_fault;
        end
    end

    // ------------------------------
    // next table pointer
    // ------------------------------
    // vpn[1] after the 1g level, vpn[0] after the 2m level
    assign next_vpn = (lvl_i == lvl_1g) ?
                      vaddr_i[`PTW_PGOFF+2*vpn_w-1:`PTW_PGOFF+vpn_w] :
                      vaddr_i[`PTW_PGOFF+vpn_w-1:`PTW_PGOFF];

    assign next_ptr_o = {pte.ppn, next_vpn, 3'b000};

endmodule

// File: src/ptw_walk_fsm.sv
/*
 * walk controller
 * state machine with level, pointer and global-bit registers,
 * memory read port, flush drain, TLB update and error outputs
 */

`include "ptw_config.svh"

module ptw_walk_fsm import ptw_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   start_i,
    input  walk_req_t              walk_i,
    input  mem_rsp_t               mem_rsp_i,
    input  pte_verdict_e           verdict_i,
    input  logic [`PTW_PLEN-1:0]   next_ptr_i,
    output logic                   busy_o,
    output mem_req_t               mem_req_o,
    output pte_word_u              pte_o,
    output ptw_lvl_e               lvl_o,
    output logic                   is_instr_o,
    output logic                   is_store_o,
    output logic [`PTW_VLEN-1:0]   vaddr_o,
    output tlb_update_t            update_o,
    output logic                   error_o,
    output logic                   active_o
);

    typedef enum logic [2:0] {
        s_idle,
        s_wait_grant,
        s_pte_lookup,
        s_propagate_error,
        s_wait_rvalid
    } state_e;

    state_e                  state_q, state_d;
    ptw_lvl_e                lvl_q, lvl_d;
    logic [`PTW_PLEN-1:0]    ptr_q, ptr_d;
    logic [`PTW_VLEN-1:0]    vaddr_q, vaddr_d;
    logic [`PTW_ASIDW-1:0]   asid_q, asid_d;
    logic                    is_instr_q, is_instr_d;
    logic                    is_store_q, is_store_d;
    logic                    global_q, global_d;
    // input registers on the response
    logic                    rvalid_q;
    logic [63:0]             rdata_q;
    logic                    upd_valid;
    pte_word_u               content;

    assign pte_o      = rdata_q;
    assign lvl_o      = lvl_q;
    assign is_instr_o = is_instr_q;
    assign is_store_o = is_store_q;
    assign vaddr_o    = vaddr_q;

    // busy already in the start cycle so the same miss is not taken twice
    assign busy_o   = (state_q != s_idle) | start_i;
    assign active_o = state_q != s_idle;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_d       = state_q;
        lvl_d         = lvl_q;
        ptr_d         = ptr_q;
        vaddr_d       = vaddr_q;
        asid_d        = asid_q;
        is_instr_d    = is_instr_q;
        is_store_d    = is_store_q;
        global_d      = global_q;
        mem_req_o.req  = 1'b0;
        mem_req_o.addr = ptr_q;
        upd_valid     = 1'b0;
        error_o       = 1'b0;

        case (state_q)
            s_idle: begin
                lvl_d    = lvl_1g;
                global_d = 1'b0;
                // root request goes out in the start cycle itself
                if (start_i && !flush_i) begin
                    vaddr_d        = walk_i.vaddr;
                    asid_d         = walk_i.asid;
                    is_instr_d     = walk_i.is_instr;
                    is_store_d     = walk_i.is_store;
                    ptr_d          = walk_i.root_ptr;
                    mem_req_o.req  = 1'b1;
                    mem_req_o.addr = walk_i.root_ptr;
                    state_d        = mem_rsp_i.gnt ? s_pte_lookup : s_wait_grant;
                end
            end
            s_wait_grant: begin
                mem_req_o.req = 1'b1;
                if (mem_rsp_i.gnt) begin
                    state_d = s_pte_lookup;
                end
            end
            s_pte_lookup: begin
                if (rvalid_q) begin
                    // g on any level makes the mapping global
                    global_d = global_q | pte_o.fields.g;
                    case (verdict_i)
                        v_leaf: begin
                            upd_valid = 1'b1;
                            state_d   = s_idle;
                        end
                        v_next: begin
                            lvl_d   = (lvl_q == lvl_1g) ? lvl_2m : lvl_4k;
                            ptr_d   = next_ptr_i;
                            state_d = s_wait_grant;
                        end
                        default: state_d = s_propagate_error;
                    endcase
                end
            end
            s_propagate_error: begin
                error_o = 1'b1;
                state_d = s_idle;
            end
            s_wait_rvalid: begin
                // drain the read that was granted before the flush
                if (rvalid_q) begin
                    state_d = s_idle;
                end
            end
            default: state_d = s_idle;
        endcase

        // ------------------------------
        // flush
        // ------------------------------
        if (flush_i) begin
            upd_valid = 1'b0;
            if (state_q == s_wait_grant) begin
                state_d = mem_rsp_i.gnt ? s_wait_rvalid : s_idle;
            end else if (state_q == s_pte_lookup) begin
                state_d = rvalid_q ? s_idle : s_wait_rvalid;
            end
        end
    end

    // leaf content with the accumulated global bit
    always_comb begin
        content          = pte_o;
        content.fields.g = pte_o.fields.g | global_q;
    end

    always_comb begin
        update_o.valid    = upd_valid;
        update_o.is_instr = is_instr_q;
        update_o.is_2m    = lvl_q == lvl_2m;
        update_o.is_1g    = lvl_q == lvl_1g;
        update_o.vpn      = vaddr_q[`PTW_VLEN-1:`PTW_PGOFF];
        update_o.asid     = asid_q;
        update_o.content  = content.raw;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= s_idle;
            lvl_q      <= lvl_1g;
            global_q   <= 1'b0;
            is_instr_q <= 1'b0;
            is_store_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            global_q   <= global_d;
            is_instr_q <= is_instr_d;
            is_store_q <= is_store_d;
            rvalid_q   <= mem_rsp_i.rvalid;
        end
    end

    // walk payload and response data
    always_ff @(posedge clk_i) begin
        ptr_q   <= ptr_d;
        vaddr_q <= vaddr_d;
        asid_q  <= asid_d;
        rdata_q <= mem_rsp_i.rdata;
    end

endmodule

// File: src/ptw_top.sv
/*
 * Sv39 page-table walker top level
 * miss selector, walk controller and PTE checker
 */

`include "ptw_config.svh"

module ptw_top import ptw_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   en_instr_i,
    input  logic                   en_data_i,
    input  logic                   itlb_access_i,
    input  logic                   itlb_hit_i,
    input  logic [`PTW_VLEN-1:0]   itlb_vaddr_i,
    input  logic                   dtlb_access_i,
    input  logic                   dtlb_hit_i,
    input  logic [`PTW_VLEN-1:0]   dtlb_vaddr_i,
    input  logic                   lsu_is_store_i,
    input  logic [`PTW_ASIDW-1:0]  asid_i,
    input  logic [`PTW_PPNW-1:0]   satp_ppn_i,
    input  logic                   mxr_i,
    output mem_req_t               mem_req_o,
    input  mem_rsp_t               mem_rsp_i,
    output tlb_update_t            update_o,
    output logic                   error_o,
    output logic                   active_o,
    output logic                   itlb_miss_o,
    output logic                   dtlb_miss_o
);

    // selector to controller
    logic                  busy;
    logic                  start;
    walk_req_t             walk;
    // controller to checker and back
    pte_word_u             pte;
    ptw_lvl_e              lvl;
    logic                  is_instr;
    logic                  is_store;
    logic [`PTW_VLEN-1:0]  vaddr;
    pte_verdict_e          verdict;
    logic [`PTW_PLEN-1:0]  next_ptr;

    ptw_miss_select u_miss_select (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .busy_i         (busy),
        .en_instr_i     (en_instr_i),
        .en_data_i      (en_data_i),
        .itlb_access_i  (itlb_access_i),
        .itlb_hit_i     (itlb_hit_i),
        .dtlb_access_i  (dtlb_access_i),
        .dtlb_hit_i     (dtlb_hit_i),
        .itlb_vaddr_i   (itlb_vaddr_i),
        .dtlb_vaddr_i   (dtlb_vaddr_i),
        .lsu_is_store_i (lsu_is_store_i),
        .asid_i         (asid_i),
        .satp_ppn_i     (satp_ppn_i),
        .start_o        (start),
        .walk_o         (walk),
        .itlb_miss_o    (itlb_miss_o),
        .dtlb_miss_o    (dtlb_miss_o)
    );

    ptw_walk_fsm u_walk_fsm (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .start_i    (start),
        .walk_i     (walk),
        .mem_rsp_i  (mem_rsp_i),
        .verdict_i  (verdict),
        .next_ptr_i (next_ptr),
        .busy_o     (busy),
        .mem_req_o  (mem_req_o),
        .pte_o      (pte),
        .lvl_o      (lvl),
        .is_instr_o (is_instr),
        .is_store_o (is_store),
        .vaddr_o    (vaddr),
        .update_o   (update_o),
        .error_o    (error_o),
        .active_o   (active_o)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (pte),
        .lvl_i      (lvl),
        .is_instr_i (is_instr),
        .is_store_i (is_store),
        .mxr_i      (mxr_i),
        .vaddr_i    (vaddr),
        .verdict_o  (verdict),
        .next_ptr_o (next_ptr)
    );

endmodule

// File: testbench/ptw_checker.sv
/*
 * bound assertions on the walker top-level ports
 * memory request hold, update/error exclusion, reset levels
 */

module ptw_checker import ptw_pkg::*; (
    input logic         clk_i,
    input logic         rst_ni,
    input logic         flush_i,
    input mem_req_t     mem_req_o,
    input mem_rsp_t     mem_rsp_i,
    input tlb_update_t  update_o,
    input logic         error_o,
    input logic         active_o,
    input logic         itlb_miss_o,
    input logic         dtlb_miss_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // request held with a stable address until granted
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.req && !mem_rsp_i.gnt && !flush_i |=>
        mem_req_o.req && $stable(mem_req_o.addr))
        else $error("memory request dropped or changed before grant");

    // a walk ends one way only
    end_excl: assert property (@(posedge clk_i) !(update_o.valid && error_o))
        else $error("update and error in the same cycle");

    // quiet outputs while reset is held
    reset_quiet: assert property (@(posedge clk_i) !rst_ni |->
        !mem_req_o.req && !update_o.valid && !error_o && !active_o &&
        !itlb_miss_o && !dtlb_miss_o)
        else $error("control output high during reset");

endmodule

// File: testbench/ptw_tb.sv
/*
 * testbench for the Sv39 page-table walker
 * clock, reset, page-table memory model with random grant and
 * response delays, walk table, check task, timeout and summary
 */

`include "ptw_config.svh"

module ptw_tb import ptw_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // one row of the walk table
    typedef struct packed {
        logic                  is_instr;
        logic                  both;
        logic                  is_store;
        logic                  mxr;
        logic                  flush_gnt;
        logic                  exp_err;
        logic                  exp_2m;
        logic                  exp_1g;
        logic [`PTW_VLEN-1:0]  vaddr;
        logic [63:0]           content;
    } walk_t;

    localparam logic [`PTW_PPNW-1:0]  satp_ppn = 44'h100;
    localparam logic [`PTW_ASIDW-1:0] asid     = 16'h5a;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  flush_i;
    logic                  en_instr_i;
    logic                  en_data_i;
    logic                  itlb_access_i;
    logic                  itlb_hit_i;
    logic [`PTW_VLEN-1:0]  itlb_vaddr_i;
    logic                  dtlb_access_i;
    logic                  dtlb_hit_i;
    logic [`PTW_VLEN-1:0]  dtlb_vaddr_i;
    logic                  lsu_is_store_i;
    logic [`PTW_ASIDW-1:0] asid_i;
    logic [`PTW_PPNW-1:0]  satp_ppn_i;
    logic                  mxr_i;
    mem_req_t              mem_req_o;
    mem_rsp_t              mem_rsp_i = '0;
    tlb_update_t           update_o;
    logic                  error_o;
    logic                  active_o;
    logic                  itlb_miss_o;
    logic                  dtlb_miss_o;

    // page tables indexed by physical address
    logic [63:0]           pt_mem [logic [`PTW_PLEN-1:0]];
    logic [`PTW_PLEN-1:0]  pend_addr;
    int                    gnt_wait;
    int                    rsp_wait;
    integer                seed = 70;

    walk_t  walks[$];
    string  names[$];
    int     err_cnt = 0;
    int     fail_tests = 0;
    int     cycle_cnt = 0;
    int     cycle_limit = 0;

    ptw_top dut0 (.*);

    bind ptw_top ptw_checker chk0 (.*);

    always #4 clk_i = ~clk_i;

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [63:0] mk_pte(input logic [`PTW_PPNW-1:0] ppn,
                                           input logic [7:0] flags);
        // flag byte is d a g u x w r v from the msb down
        mk_pte = {10'b0, ppn, 2'b0, flags};
    endfunction

    // unwritten entries read as an rwx 1g leaf whose ppn folds in every address bit
    function automatic logic [63:0] fill_pte(input logic [`PTW_PLEN-1:0] addr);
        logic [25:0] tag;
        tag = addr[25:0] ^ addr[51:26] ^ 26'(addr[55:52]);
        fill_pte = mk_pte({tag, 18'h0}, 8'hcf);
    endfunction

    function automatic logic [`PTW_PLEN-1:0] entry_addr(input logic [`PTW_PPNW-1:0] ppn,
                                                        input logic [8:0] idx);
        entry_addr = {ppn, idx, 3'b000};
    endfunction

    function automatic logic [`PTW_VLEN-1:0] mk_va(input logic [8:0] vpn2,
                                                   input logic [8:0] vpn1,
                                                   input logic [8:0] vpn0);
        mk_va = {vpn2, vpn1, vpn0, 12'h000};
    endfunction

    task automatic add_walk(input string nm, input walk_t w);
        names.push_back(nm);
        walks.push_back(w);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("Error %s %s: expected %h, actual %h", test, what, exp, act);
        end
    endtask

    // ------------------------------
    // memory model
    // ------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_rsp_i <= '0;
            gnt_wait  = 0;
            rsp_wait  = 0;
        end else begin
            mem_rsp_i.rvalid <= 1'b0;
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    mem_rsp_i.rvalid <= 1'b1;
                    mem_rsp_i.rdata  <= pt_mem.exists(pend_addr) ?
                                        pt_mem[pend_addr] : fill_pte(pend_addr);
                end
            end
            if (mem_req_o.req && mem_rsp_i.gnt) begin
                // response follows 1 to 3 cycles after the grant
                mem_rsp_i.gnt <= 1'b0;
                pend_addr = mem_req_o.addr;
                rsp_wait  = (($random(seed) & 32'h7fff) % 3) + 1;
            end else if (mem_req_o.req) begin
                if (gnt_wait == 0) begin
                    mem_rsp_i.gnt <= 1'b1;
                end else begin
                    gnt_wait--;
                end
            end else begin
                mem_rsp_i.gnt <= 1'b0;
                gnt_wait = $random(seed) & 32'h3;
            end
        end
    end

    // run limit from the table length
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: walks did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------
    // one walk
    // ------------------------------
    task automatic run_walk(input int idx);
        walk_t        w;
        string        nm;
        int           errs0;
        int           itlb_cnt;
        int           dtlb_cnt;
        logic         got_upd;
        logic         got_err;
        logic         flushed;
        logic         rv_seen;
        logic         done;
        tlb_update_t  upd;

        w = walks[idx];
        nm = names[idx];
        errs0 = err_cnt;
        itlb_cnt = 0;
        dtlb_cnt = 0;
        got_upd = 1'b0;
        got_err = 1'b0;
        flushed = 1'b0;
        rv_seen = 1'b0;
        done = 1'b0;
        upd = '0;

        @(posedge clk_i);
        mxr_i          <= w.mxr;
        lsu_is_store_i <= w.is_store;
        itlb_access_i  <= w.is_instr | w.both;
        itlb_vaddr_i   <= w.is_instr ? w.vaddr : mk_va(9'd2, 9'd0, 9'd0);
        dtlb_access_i  <= ~w.is_instr;
        dtlb_vaddr_i   <= w.vaddr;
        @(posedge clk_i);
        itlb_cnt += int'(itlb_miss_o);
        dtlb_cnt += int'(dtlb_miss_o);
        itlb_access_i <= 1'b0;
        dtlb_access_i <= 1'b0;

        while (!done) begin
            @(posedge clk_i);
            itlb_cnt += int'(itlb_miss_o);
            dtlb_cnt += int'(dtlb_miss_o);
            // the drained response has to arrive while active_o is still high
            if (flushed && !active_o) begin
                done = 1'b1;
            end else if (flushed && mem_rsp_i.rvalid) begin
                rv_seen = 1'b1;
            end
            // flush right after the first grant and before its response
            if (w.flush_gnt && !flushed && mem_req_o.req && mem_rsp_i.gnt) begin
                flush_i <= 1'b1;
                flushed = 1'b1;
            end else begin
                flush_i <= 1'b0;
            end
            if (update_o.valid) begin
                got_upd = 1'b1;
                upd = update_o;
                done = 1'b1;
            end
            if (error_o) begin
                got_err = 1'b1;
                done = 1'b1;
            end
        end

        if (w.flush_gnt) begin
            check_value(nm, "drained response", 64'h1, 64'(rv_seen));
            check_value(nm, "update", 64'h0, 64'(got_upd));
            check_value(nm, "error", 64'h0, 64'(got_err));
        end else begin
            check_value(nm, "itlb miss pulses", 64'(w.is_instr), 64'(itlb_cnt));
            check_value(nm, "dtlb miss pulses", 64'(!w.is_instr), 64'(dtlb_cnt));
            check_value(nm, "error", 64'(w.exp_err), 64'(got_err));
            check_value(nm, "update", 64'(!w.exp_err), 64'(got_upd));
            if (got_upd && !w.exp_err) begin
                check_value(nm, "is_instr", 64'(w.is_instr), 64'(upd.is_instr));
                check_value(nm, "is_2m", 64'(w.exp_2m), 64'(upd.is_2m));
                check_value(nm, "is_1g", 64'(w.exp_1g), 64'(upd.is_1g));
                check_value(nm, "vpn", 64'(w.vaddr[38:12]), 64'(upd.vpn));
                check_value(nm, "asid", 64'(asid), 64'(upd.asid));
                check_value(nm, "content", w.content, upd.content);
            end
        end

        if (err_cnt == errs0) begin
            $display("test %s ok", nm);
        end else begin
            fail_tests++;
            $display("test %s failed", nm);
        end
        repeat (2) @(posedge clk_i);
    endtask

    // ------------------------------
    // page tables and walk table
    // ------------------------------
    initial begin
        logic [63:0] leaf_4k;

        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        en_instr_i     = 1'b1;
        en_data_i      = 1'b1;
        itlb_access_i  = 1'b0;
        itlb_hit_i     = 1'b0;
        itlb_vaddr_i   = '0;
        dtlb_access_i  = 1'b0;
        dtlb_hit_i     = 1'b0;
        dtlb_vaddr_i   = '0;
        lsu_is_store_i = 1'b0;
        asid_i         = asid;
        satp_ppn_i     = satp_ppn;
        mxr_i          = 1'b0;

        // three levels with g set on the root pointer
        leaf_4k = mk_pte(44'h12345, 8'hc3);
        pt_mem[entry_addr(satp_ppn, 9'd1)] = mk_pte(44'h200, 8'h21);
        pt_mem[entry_addr(44'h200, 9'd2)]  = mk_pte(44'h300, 8'h01);
        pt_mem[entry_addr(44'h300, 9'd3)]  = leaf_4k;
        // 1g execute leaf
        pt_mem[entry_addr(satp_ppn, 9'd2)] = mk_pte(44'h40000, 8'h49);
        // 2m leaf
        pt_mem[entry_addr(satp_ppn, 9'd3)] = mk_pte(44'h201, 8'h01);
        pt_mem[entry_addr(44'h201, 9'd0)]  = mk_pte(44'h400, 8'h4b);
        // faults
        pt_mem[entry_addr(satp_ppn, 9'd4)] = 64'h0;
        pt_mem[entry_addr(satp_ppn, 9'd5)] = mk_pte(44'h80000, 8'h45);
        pt_mem[entry_addr(satp_ppn, 9'd6)] = mk_pte(44'h202, 8'h01);
        pt_mem[entry_addr(44'h202, 9'd0)]  = mk_pte(44'h401, 8'h43);
        pt_mem[entry_addr(satp_ppn, 9'd7)] = mk_pte(44'h203, 8'h01);
        pt_mem[entry_addr(44'h203, 9'd0)]  = mk_pte(44'h301, 8'h01);
        pt_mem[entry_addr(44'h301, 9'd0)]  = mk_pte(44'h302, 8'h01);
        // permission pages
        pt_mem[entry_addr(satp_ppn, 9'd8)]  = mk_pte(44'h80000, 8'h47);
        pt_mem[entry_addr(satp_ppn, 9'd9)]  = mk_pte(44'hc0000, 8'h49);
        pt_mem[entry_addr(satp_ppn, 9'd10)] = mk_pte(44'h100000, 8'h43);

        // instr both store mxr flush err 2m 1g vaddr content
        add_walk("load_4k", {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                 mk_va(9'd1, 9'd2, 9'd3), leaf_4k | 64'h20});
        add_walk("fetch_1g", {1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                 mk_va(9'd2, 9'd5, 9'd6), mk_pte(44'h40000, 8'h49)});
        add_walk("fetch_2m", {1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                 mk_va(9'd3, 9'd0, 9'd7), mk_pte(44'h400, 8'h4b)});
        add_walk("both_miss", {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                 mk_va(9'd1, 9'd2, 9'd3), leaf_4k | 64'h20});
        add_walk("invalid_pte", {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                 mk_va(9'd4, 9'd0, 9'd0), 64'h0});
        add_walk("w_without_r", {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                 mk_va(9'd5, 9'd0, 9'd0), 64'h0});
        add_walk("misaligned_2m", {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                 mk_va(9'd6, 9'd0, 9'd0), 64'h0});
        add_walk("pointer_at_4k", {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                 mk_va(9'd7, 9'd0, 9'd0), 64'h0});
        add_walk("store_no_d", {1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                 mk_va(9'd8, 9'd0, 9'd0), 64'h0});
        add_walk("load_xonly", {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                 mk_va(9'd9, 9'd0, 9'd0), 64'h0});
        add_walk("load_xonly_mxr", {1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1,
                 mk_va(9'd9, 9'd1, 9'd1), mk_pte(44'hc0000, 8'h49)});
        add_walk("fetch_no_x", {1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                 mk_va(9'd10, 9'd0, 9'd0), 64'h0});
        add_walk("flush_drain", {1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                 mk_va(9'd1, 9'd2, 9'd3), 64'h0});
        add_walk("after_flush", {1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                 mk_va(9'd3, 9'd0, 9'd7), mk_pte(44'h400, 8'h4b)});

        cycle_limit = 200 * walks.size() + 10;

        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (int i = 0; i < walks.size(); i++) begin
            run_walk(i);
        end

        $display("%0d tests, %0d failed, %0d check errors",
                 walks.size(), fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: ptw_top.f
+incdir+src
src/ptw_pkg.sv
src/ptw_miss_select.sv
src/ptw_pte_check.sv
src/ptw_walk_fsm.sv
src/ptw_top.sv
testbench/ptw_checker.sv
testbench/ptw_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the walker testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f ptw_top.f --top-module ptw_tb -o ptw_sim

./obj_dir/ptw_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
grep -q "Simulation PASSED" sim.log
